// File: src/icache_defs.svh
// Geometry of the instruction cache. Only 2 ways are supported,
// so the way count has no macro here
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

`define ICACHE_ADDR_BITS    32
`define ICACHE_OFFSET_BITS  4   // 16-byte lines
`define ICACHE_LINE_WORDS   4
`define ICACHE_SET_BITS     4   // 16 sets

// Address bits above offset and set index
`define ICACHE_TAG_BITS     (`ICACHE_ADDR_BITS - `ICACHE_OFFSET_BITS - `ICACHE_SET_BITS)

`endif

// File: src/icache_pkg.sv
// Shared types of the instruction cache
// Word 0 of a line sits in the low 32 bits
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0]       addr_t;
    typedef logic [31:0]                        word_t;
    typedef logic [`ICACHE_LINE_WORDS*32-1:0]   line_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]        tag_t;
    typedef logic [`ICACHE_SET_BITS-1:0]        set_idx_t;

    // Controller FSM
    typedef enum logic [2:0] {
        INIT,       // Power-on invalidate sweep
        IDLE,
        LOOKUP,
        FILL,
        WRITE,
        RESPOND,
        FLUSH
    } ctrl_state_e;

endpackage

// File: src/icache_tag_mem.sv
// Two-way tag and data store with one LRU bit per set
// Valid and LRU bits start unknown until the controller's power-on sweep
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_tag_mem (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_rd_en,
    input  icache_pkg::set_idx_t    i_rd_idx,
    input  icache_pkg::tag_t        i_rd_tag,
    output logic                    o_hit,
    output logic                    o_hit_way,
    output icache_pkg::line_t       o_rd_line,
    output logic                    o_victim_way,
    input  logic                    i_wr_en,
    input  logic                    i_wr_way,
    input  icache_pkg::set_idx_t    i_wr_idx,
    input  icache_pkg::tag_t        i_wr_tag,
    input  icache_pkg::line_t       i_wr_line,
    input  logic                    i_inv_en,
    input  logic                    i_inv_all,
    input  icache_pkg::set_idx_t    i_inv_idx,
    input  icache_pkg::tag_t        i_inv_tag
);
    import icache_pkg::*;

    localparam int SETS = 1 << `ICACHE_SET_BITS;

    tag_t            tag_q   [2][SETS];
    line_t           data_q  [2][SETS];
    logic [SETS-1:0] valid_q [2];
    logic [SETS-1:0] lru_q;         // Next victim way per set

    logic            rd_pend_q;     // Lookup result is on the outputs this cycle
    set_idx_t        rd_idx_q;
    tag_t            rd_tag_q;
    logic [1:0]      way_hit;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= i_rd_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            rd_idx_q <= i_rd_idx;
            rd_tag_q <= i_rd_tag;
        end
    end

    assign way_hit[0] = valid_q[0][rd_idx_q] && (tag_q[0][rd_idx_q] == rd_tag_q);
    assign way_hit[1] = valid_q[1][rd_idx_q] && (tag_q[1][rd_idx_q] == rd_tag_q);

    assign o_hit        = |way_hit;
    assign o_hit_way    = way_hit[1];
    assign o_rd_line    = way_hit[1] ? data_q[1][rd_idx_q] : data_q[0][rd_idx_q];
    assign o_victim_way = lru_q[i_rd_idx];

    // Line payload
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            tag_q[i_wr_way][i_wr_idx]  <= i_wr_tag;
            data_q[i_wr_way][i_wr_idx] <= i_wr_line;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            valid_q[i_wr_way][i_wr_idx] <= 1'b1;
            lru_q[i_wr_idx]             <= ~i_wr_way;   // Other way goes next
        end else if (i_inv_en) begin
            if (i_inv_all) begin
                valid_q[0][i_inv_idx] <= 1'b0;
                valid_q[1][i_inv_idx] <= 1'b0;
                lru_q[i_inv_idx]      <= 1'b0;
            end else begin
                for (int w = 0; w < 2; w++) begin
                    if (tag_q[w][i_inv_idx] == i_inv_tag) begin
                        valid_q[w][i_inv_idx] <= 1'b0;
                    end
                end
            end
        end else if (rd_pend_q && o_hit) begin
            lru_q[rd_idx_q] <= ~o_hit_way;   // Only on the first cycle of a lookup
        end
    end

    // Controller keeps fills and flushes apart
    wr_inv_excl_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_wr_en && i_inv_en));

endmodule

// File: src/icache_fill_master.sv
// Read-only Wishbone classic master with one cycle open at a time
// Line reads start at the line-aligned address, single reads fetch one word
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_fill_master (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic                i_fill_start,
    input  icache_pkg::addr_t   i_fill_addr,
    input  logic                i_fill_line_mode,
    output logic                o_fill_done,
    output icache_pkg::line_t   o_fill_line,
    output logic                o_fill_err,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output icache_pkg::addr_t   o_wb_adr,
    output logic [3:0]          o_wb_sel,
    input  icache_pkg::word_t   i_wb_dat,
    input  logic                i_wb_ack,
    input  logic                i_wb_err
);
    import icache_pkg::*;

    localparam int    CNT_BITS  = $clog2(`ICACHE_LINE_WORDS);
    localparam addr_t LINE_MASK = addr_t'((1 << `ICACHE_OFFSET_BITS) - 1);

    logic                busy_q;
    logic                done_q;
    logic                err_q;
    logic                line_mode_q;
    logic [CNT_BITS-1:0] cnt_q;         // Words acked so far
    addr_t               adr_q;
    line_t               line_q;
    logic                last_word;
    logic [CNT_BITS-1:0] slot;

    assign last_word = !line_mode_q || (cnt_q == CNT_BITS'(`ICACHE_LINE_WORDS - 1));
    assign slot      = adr_q[`ICACHE_OFFSET_BITS-1:2];  // Same slot rule in both modes

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (i_fill_start) begin
                busy_q <= 1'b1;
            end else if (busy_q && (i_wb_err || (i_wb_ack && last_word))) begin
                busy_q <= 1'b0;     // Error closes the cycle at once
                done_q <= 1'b1;
                err_q  <= i_wb_err;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fill_start) begin
            line_mode_q <= i_fill_line_mode;
            cnt_q       <= '0;
            adr_q       <= i_fill_line_mode ? (i_fill_addr & ~LINE_MASK)
                                            : (i_fill_addr & ~addr_t'(3));
        end else if (busy_q && i_wb_ack) begin
            line_q[slot*32 +: 32] <= i_wb_dat;
            cnt_q                 <= cnt_q + 1'b1;
            adr_q                 <= adr_q + addr_t'(4);
        end
    end

    assign o_wb_cyc    = busy_q;
    assign o_wb_stb    = busy_q;
    assign o_wb_adr    = adr_q;
    assign o_wb_sel    = 4'hF;   // Full words only
    assign o_fill_done = done_q;
    assign o_fill_line = line_q;
    assign o_fill_err  = err_q;

    // Classic cycle holds stb inside cyc and keeps the address until ack or err
    stb_hold_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_wb_stb && !i_wb_ack && !i_wb_err)
            |=> (o_wb_cyc && o_wb_stb && $stable(o_wb_adr)));

    // Controller waits for fill_done before the next start
    start_when_idle_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_fill_start |-> !busy_q);

endmodule

// File: src/icache_ctrl.sv
// Cache FSM with one fetch in flight. Requests are refused until the
// power-on sweep ends, and a pending flush always goes ahead of a fetch
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_req_valid,
    input  icache_pkg::addr_t       i_req_addr,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output icache_pkg::addr_t       o_resp_addr,
    output icache_pkg::word_t       o_resp_data,
    output logic                    o_resp_fault,
    input  logic                    i_resp_ready,
    output icache_pkg::addr_t       o_mpu_addr,
    input  logic                    i_pma_cached,
    input  logic                    i_pmp_x,
    input  logic                    i_flush_valid,
    input  icache_pkg::addr_t       i_flush_addr,
    output logic                    o_fill_start,
    output icache_pkg::addr_t       o_fill_addr,
    output logic                    o_fill_line_mode,
    input  logic                    i_fill_done,
    input  icache_pkg::line_t       i_fill_line,
    input  logic                    i_fill_err,
    output logic                    o_rd_en,
    output icache_pkg::set_idx_t    o_rd_idx,
    output icache_pkg::tag_t        o_rd_tag,
    input  logic                    i_hit,
    input  logic                    i_hit_way,
    input  icache_pkg::line_t       i_rd_line,
    input  logic                    i_victim_way,
    output logic                    o_wr_en,
    output logic                    o_wr_way,
    output icache_pkg::set_idx_t    o_wr_idx,
    output icache_pkg::tag_t        o_wr_tag,
    output icache_pkg::line_t       o_wr_line,
    output logic                    o_inv_en,
    output logic                    o_inv_all,
    output icache_pkg::set_idx_t    o_inv_idx,
    output icache_pkg::tag_t        o_inv_tag
);
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    set_idx_t    cnt_q;          // Sweep position for INIT and flush-all
    logic        flush_pend_q;
    addr_t       flush_addr_q;   // Bit 0 selects flush-all
    addr_t       req_addr_q;
    logic        cached_q;
    logic        fault_q;
    logic [1:0]  word_sel;
    word_t       hit_word;
    word_t       fill_word;

    assign word_sel  = req_addr_q[`ICACHE_OFFSET_BITS-1:2];
    assign hit_word  = i_rd_line[word_sel*32 +: 32];
    assign fill_word = i_fill_line[word_sel*32 +: 32];

    always_comb begin
        state_d      = state_q;
        o_rd_en      = 1'b0;
        o_fill_start = 1'b0;
        o_wr_en      = 1'b0;
        o_inv_en     = 1'b0;
        o_resp_valid = 1'b0;
        case (state_q)
            INIT: begin
                o_inv_en = 1'b1;
                if (&cnt_q) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (flush_pend_q) begin
                    state_d = FLUSH;
                end else if (i_req_valid) begin
                    o_rd_en = 1'b1;
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (i_hit) begin
                    o_resp_valid = 1'b1;    // Tag memory output holds while stalled
                    if (i_resp_ready) begin
                        state_d = IDLE;
                    end
                end else if (!i_pmp_x) begin
                    state_d = RESPOND;      // Denied fetch never reaches the bus
                end else begin
                    o_fill_start = 1'b1;
                    state_d      = FILL;
                end
            end
            FILL: begin
                if (i_fill_done) begin
                    state_d = (cached_q && !i_fill_err) ? WRITE : RESPOND;
                end
            end
            WRITE: begin
                o_wr_en = 1'b1;
                state_d = RESPOND;
            end
            RESPOND: begin
                o_resp_valid = 1'b1;
                if (i_resp_ready) begin
                    state_d = IDLE;
                end
            end
            FLUSH: begin
                o_inv_en = 1'b1;
                if (!flush_addr_q[0] || (&cnt_q)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q      <= INIT;
            cnt_q        <= '0;
            flush_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_inv_en && o_inv_all) begin
                cnt_q <= cnt_q + 1'b1;      // Wraps back to 0 after a full sweep
            end
            if (state_q == IDLE) begin
                flush_pend_q <= 1'b0;
            end
            if (i_flush_valid) begin
                flush_pend_q <= 1'b1;       // New pulse wins over the clear
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_rd_en) begin
            req_addr_q <= i_req_addr;
        end
        if (i_flush_valid) begin
            flush_addr_q <= i_flush_addr;
        end
        if (o_fill_start) begin
            cached_q <= i_pma_cached;
        end
        if (state_q == LOOKUP && !i_hit) begin
            fault_q <= !i_pmp_x;
        end else if (i_fill_done) begin
            fault_q <= i_fill_err;
        end
    end

    assign o_req_ready  = (state_q == IDLE) && !flush_pend_q;
    assign o_resp_addr  = req_addr_q;
    assign o_resp_fault = (state_q == RESPOND) && fault_q;
    assign o_resp_data  = (state_q == LOOKUP) ? hit_word : (fault_q ? '1 : fill_word);
    assign o_mpu_addr   = req_addr_q;

    assign o_fill_addr      = req_addr_q;
    assign o_fill_line_mode = i_pma_cached;

    // Lookup takes the incoming address, WRITE needs the victim of the held one
    assign o_rd_idx = (state_q == IDLE) ? i_req_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS]
                                        : req_addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign o_rd_tag = i_req_addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];

    assign o_wr_way  = i_victim_way;
    assign o_wr_idx  = req_addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign o_wr_tag  = req_addr_q[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign o_wr_line = i_fill_line;

    assign o_inv_all = (state_q == INIT) || flush_addr_q[0];
    assign o_inv_idx = o_inv_all ? cnt_q
                                 : flush_addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign o_inv_tag = flush_addr_q[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];

    // Sweeps never overlap a response or a finishing line fill
    no_resp_in_sweep_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state_q inside {INIT, FLUSH}) |-> (!o_resp_valid && !i_fill_done));

    // A stalled response keeps its fields until taken
    resp_hold_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp_data)
            && $stable(o_resp_addr) && $stable(o_resp_fault)));

endmodule

// File: src/icache_top.sv
// Instruction cache top. 2 ways x 16 sets x 16-byte lines, read-only
// Wishbone classic fill port, word-aligned fetches only
`timescale 1ns/100ps

module icache_top (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic                i_req_valid,
    input  icache_pkg::addr_t   i_req_addr,
    output logic                o_req_ready,
    output logic                o_resp_valid,
    output icache_pkg::addr_t   o_resp_addr,
    output icache_pkg::word_t   o_resp_data,
    output logic                o_resp_fault,
    input  logic                i_resp_ready,
    output icache_pkg::addr_t   o_mpu_addr,
    input  logic                i_pma_cached,
    input  logic                i_pmp_x,
    input  logic                i_flush_valid,
    input  icache_pkg::addr_t   i_flush_addr,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output icache_pkg::addr_t   o_wb_adr,
    output logic [3:0]          o_wb_sel,
    input  icache_pkg::word_t   i_wb_dat,
    input  logic                i_wb_ack,
    input  logic                i_wb_err
);
    import icache_pkg::*;

    // Controller to fill master
    logic     fill_start;
    addr_t    fill_addr;
    logic     fill_line_mode;
    logic     fill_done;
    line_t    fill_line;
    logic     fill_err;

    // Controller to tag memory
    logic     rd_en;
    set_idx_t rd_idx;
    tag_t     rd_tag;
    logic     hit;
    logic     hit_way;
    line_t    rd_line;
    logic     victim_way;
    logic     wr_en;
    logic     wr_way;
    set_idx_t wr_idx;
    tag_t     wr_tag;
    line_t    wr_line;
    logic     inv_en;
    logic     inv_all;
    set_idx_t inv_idx;
    tag_t     inv_tag;

    // Outside ports connect by name
    icache_ctrl ctrl_i (
        .*,
        .o_fill_start     (fill_start),
        .o_fill_addr      (fill_addr),
        .o_fill_line_mode (fill_line_mode),
        .i_fill_done      (fill_done),
        .i_fill_line      (fill_line),
        .i_fill_err       (fill_err),
        .o_rd_en          (rd_en),
        .o_rd_idx         (rd_idx),
        .o_rd_tag         (rd_tag),
        .i_hit            (hit),
        .i_hit_way        (hit_way),
        .i_rd_line        (rd_line),
        .i_victim_way     (victim_way),
        .o_wr_en          (wr_en),
        .o_wr_way         (wr_way),
        .o_wr_idx         (wr_idx),
        .o_wr_tag         (wr_tag),
        .o_wr_line        (wr_line),
        .o_inv_en         (inv_en),
        .o_inv_all        (inv_all),
        .o_inv_idx        (inv_idx),
        .o_inv_tag        (inv_tag)
    );

    icache_tag_mem tag_mem_i (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_rd_en      (rd_en),
        .i_rd_idx     (rd_idx),
        .i_rd_tag     (rd_tag),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_rd_line    (rd_line),
        .o_victim_way (victim_way),
        .i_wr_en      (wr_en),
        .i_wr_way     (wr_way),
        .i_wr_idx     (wr_idx),
        .i_wr_tag     (wr_tag),
        .i_wr_line    (wr_line),
        .i_inv_en     (inv_en),
        .i_inv_all    (inv_all),
        .i_inv_idx    (inv_idx),
        .i_inv_tag    (inv_tag)
    );

    icache_fill_master fill_i (
        .*,
        .i_fill_start     (fill_start),
        .i_fill_addr      (fill_addr),
        .i_fill_line_mode (fill_line_mode),
        .o_fill_done      (fill_done),
        .o_fill_line      (fill_line),
        .o_fill_err       (fill_err)
    );

endmodule

// File: verification/wb_mem_model.sv
// Read-only Wishbone classic slave. Word at address a is a ^ 32'h5a5a0000, and
// addresses from 32'hF000_0000 up answer err. sel is not decoded
`timescale 1ns/100ps

module wb_mem_model (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  icache_pkg::addr_t   i_wb_adr,
    input  logic [3:0]          i_wb_sel,
    output icache_pkg::word_t   o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_wb_err,
    output logic [31:0]         o_wb_words,
    output logic [31:0]         o_wb_errs
);
    import icache_pkg::*;

    localparam addr_t ERR_BASE = 32'hF000_0000;
    localparam word_t DATA_KEY = 32'h5a5a_0000;

    logic req;

    // New strobe, not the one just answered
    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack && !o_wb_err;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_wb_ack   <= 1'b0;
            o_wb_err   <= 1'b0;
            o_wb_dat   <= '0;
            o_wb_words <= '0;
            o_wb_errs  <= '0;
        end else begin
            o_wb_ack <= req && (i_wb_adr < ERR_BASE);   // One cycle after stb
            o_wb_err <= req && (i_wb_adr >= ERR_BASE);
            if (req) begin
                o_wb_dat <= i_wb_adr ^ DATA_KEY;
            end
            if (o_wb_ack) begin
                o_wb_words <= o_wb_words + 1'b1;
            end
            if (o_wb_err) begin
                o_wb_errs <= o_wb_errs + 1'b1;
            end
        end
    end

endmodule

// File: verification/tb_icache.sv
// Directed testbench for icache_top with a Wishbone memory model.
// Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge
`timescale 1ns/100ps

module tb_icache;
    import icache_pkg::*;

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 16;
    localparam int          RAND_FETCHES  = 12;
    localparam int          NUM_FETCHES   = 19 + RAND_FETCHES;
    localparam logic [31:0] LCG_SEED      = 32'h2e67846b;
    localparam addr_t       UNCACHED_BASE = 32'h8000_0000;
    localparam addr_t       ERR_BASE      = 32'hF000_0000;

    // Lines A, B and C share set 3
    localparam addr_t LINE_X      = 32'h0000_1004;
    localparam addr_t LRU_A       = 32'h0000_2030;
    localparam addr_t LRU_B       = 32'h0001_2030;
    localparam addr_t LRU_C       = 32'h0002_2034;
    localparam addr_t UNC_ADDR    = 32'h8000_1000;
    localparam addr_t DENIED_ADDR = 32'h4000_0100;
    localparam addr_t ERR_ADDR    = 32'hF000_0010;

    logic        clk;
    logic        nrst;
    logic        req_valid;
    addr_t       req_addr;
    logic        req_ready;
    logic        resp_valid;
    addr_t       resp_addr;
    word_t       resp_data;
    logic        resp_fault;
    logic        resp_ready;
    addr_t       mpu_addr;
    logic        pma_cached;
    logic        pmp_x;
    logic        flush_valid;
    addr_t       flush_addr;
    logic        wb_cyc;
    logic        wb_stb;
    addr_t       wb_adr;
    logic [3:0]  wb_sel;
    word_t       wb_dat;
    logic        wb_ack;
    logic        wb_err;
    logic [31:0] wb_words;
    logic [31:0] wb_errs;
    logic [31:0] lcg_state;

    icache_top dut_i (
        .i_clk         (clk),
        .i_nrst        (nrst),
        .i_req_valid   (req_valid),
        .i_req_addr    (req_addr),
        .o_req_ready   (req_ready),
        .o_resp_valid  (resp_valid),
        .o_resp_addr   (resp_addr),
        .o_resp_data   (resp_data),
        .o_resp_fault  (resp_fault),
        .i_resp_ready  (resp_ready),
        .o_mpu_addr    (mpu_addr),
        .i_pma_cached  (pma_cached),
        .i_pmp_x       (pmp_x),
        .i_flush_valid (flush_valid),
        .i_flush_addr  (flush_addr),
        .o_wb_cyc      (wb_cyc),
        .o_wb_stb      (wb_stb),
        .o_wb_adr      (wb_adr),
        .o_wb_sel      (wb_sel),
        .i_wb_dat      (wb_dat),
        .i_wb_ack      (wb_ack),
        .i_wb_err      (wb_err)
    );

    wb_mem_model mem_i (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_adr   (wb_adr),
        .i_wb_sel   (wb_sel),
        .o_wb_dat   (wb_dat),
        .o_wb_ack   (wb_ack),
        .o_wb_err   (wb_err),
        .o_wb_words (wb_words),
        .o_wb_errs  (wb_errs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic exec_denied(input addr_t a);
        return a[31:28] == 4'h4;
    endfunction

    function automatic logic bus_error(input addr_t a);
        return a >= ERR_BASE;
    endfunction

    function automatic word_t rule_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Region answers, defined even while o_mpu_addr is still unknown
    always_comb begin
        pma_cached = 1'b1;
        pmp_x      = 1'b1;
        if (mpu_addr >= UNCACHED_BASE) begin
            pma_cached = 1'b0;
        end
        if (exec_denied(mpu_addr)) begin
            pmp_x = 1'b0;
        end
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %s %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Every strobe reads a whole word inside an open cycle
    always @(negedge clk) begin
        if (nrst && wb_stb) begin
            assert (wb_cyc)
                else report_error("Wishbone stb high without cyc");
            assert (wb_sel == 4'hF)
                else report_mismatch("wishbone_sel", "sel", 32'h0000_000F, wb_sel);
        end
    end

    task automatic reset_and_init();
        int cnt;
        nrst = 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            assert (!wb_cyc && !wb_stb)
                else report_error("Wishbone cyc or stb high during reset");
            assert (!req_ready && !resp_valid)
                else report_error("request ready or response valid high during reset");
        end
        @(posedge clk);
        #2;
        nrst = 1'b1;
        cnt  = 0;
        @(negedge clk);
        while (!req_ready && cnt < 20) begin
            cnt++;
            @(negedge clk);
        end
        assert (req_ready)
            else report_error("request ready did not rise within 20 cycles of reset release");
    endtask

    // One request, optional stall on the response; exp_words below 0 skips the count
    task automatic fetch(input string name, input addr_t addr, input int stall,
                         input int exp_words, input bit want_hit);
        int    i;
        int    lat;
        int    words0;
        int    errs0;
        int    delta;
        word_t exp_data;
        logic  exp_fault;
        int    exp_errs;
        word_t hold_data;
        addr_t hold_addr;
        logic  hold_fault;

        exp_fault = exec_denied(addr) || bus_error(addr);
        exp_data  = exec_denied(addr) ? 32'hFFFF_FFFF : rule_word(addr);
        exp_errs  = (bus_error(addr) && !exec_denied(addr)) ? 1 : 0;
        words0    = wb_words;
        errs0     = wb_errs;

        @(posedge clk);
        #2;
        req_valid  = 1'b1;
        req_addr   = addr;
        resp_ready = (stall == 0);
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);            // Request taken on this edge
        #2;
        req_valid = 1'b0;
        lat       = 1;
        @(negedge clk);
        while (!resp_valid) begin
            lat++;
            @(negedge clk);
        end
        hold_data  = resp_data;
        hold_addr  = resp_addr;
        hold_fault = resp_fault;

        for (i = 0; i < stall; i++) begin
            @(posedge clk);
            #2;
            if (i == stall - 1) begin
                resp_ready = 1'b1;  // Taken on the next edge
            end
            @(negedge clk);
            assert (resp_valid)
                else report_error($sformatf("%s response dropped while stalled", name));
            assert (resp_data == hold_data)
                else report_mismatch(name, "stalled data", hold_data, resp_data);
            assert (resp_addr == hold_addr)
                else report_mismatch(name, "stalled addr", hold_addr, resp_addr);
            assert (resp_fault == hold_fault)
                else report_mismatch(name, "stalled fault", hold_fault, resp_fault);
        end
        @(posedge clk);
        @(negedge clk);

        assert (!resp_valid)
            else report_error($sformatf("%s response still valid after handshake", name));
        assert (hold_addr == addr)
            else report_mismatch(name, "addr", addr, hold_addr);
        assert (hold_fault == exp_fault)
            else report_mismatch(name, "fault", exp_fault, hold_fault);
        if (!exp_fault || exec_denied(addr)) begin
            assert (hold_data == exp_data)
                else report_mismatch(name, "data", exp_data, hold_data);
        end
        if (want_hit) begin
            assert (lat == 1)
                else report_mismatch(name, "hit latency", 32'd1, lat);
        end
        delta = wb_words - words0;
        if (exp_words >= 0) begin
            assert (delta == exp_words)
                else report_mismatch(name, "bus words", exp_words, delta);
        end
        delta = wb_errs - errs0;
        assert (delta == exp_errs)
            else report_mismatch(name, "bus errors", exp_errs, delta);
    endtask

    // Bit 0 of the address selects flush-all
    task automatic send_flush(input addr_t addr);
        @(posedge clk);
        #2;
        flush_valid = 1'b1;
        flush_addr  = addr;
        @(posedge clk);
        #2;
        flush_valid = 1'b0;
        @(negedge clk);
        while (!req_ready) begin
            assert (!resp_valid)
                else report_error("response valid raised during a flush");
            @(negedge clk);
        end
    endtask

    task automatic cold_miss_and_hit();
        fetch("cold_miss", LINE_X, 0, 4, 1'b0);
        fetch("same_line_hit", LINE_X + 8, 0, 0, 1'b1);
    endtask

    task automatic lru_replacement();
        fetch("lru_fill_a", LRU_A, 0, 4, 1'b0);
        fetch("lru_fill_b", LRU_B, 0, 4, 1'b0);
        fetch("lru_hit_a", LRU_A, 0, 0, 1'b1);
        fetch("lru_fill_c", LRU_C, 0, 4, 1'b0);     // B is the older way
        fetch("lru_keep_a", LRU_A, 0, 0, 1'b1);
        fetch("lru_refill_b", LRU_B, 0, 4, 1'b0);
    endtask

    task automatic uncached_fetches();
        fetch("uncached_first", UNC_ADDR, 0, 1, 1'b0);
        fetch("uncached_repeat", UNC_ADDR, 0, 1, 1'b0);
        fetch("uncached_next", UNC_ADDR + 8, 0, 1, 1'b0);
    endtask

    task automatic fault_fetches();
        fetch("exec_denied", DENIED_ADDR, 0, 0, 1'b0);
        fetch("bus_error", ERR_ADDR, 0, 0, 1'b0);
        fetch("bus_error_repeat", ERR_ADDR, 0, 0, 1'b0);
    endtask

    task automatic flush_and_refetch();
        send_flush(LRU_A);
        fetch("flush_line_a", LRU_A, 0, 4, 1'b0);
        fetch("flush_line_b", LRU_B, 0, 0, 1'b1);
        send_flush(32'h0000_0001);
        fetch("flush_all_a", LRU_A, 0, 4, 1'b0);
        fetch("flush_all_b", LRU_B, 0, 4, 1'b0);
        fetch("flush_all_x", LINE_X, 0, 4, 1'b0);
    endtask

    task automatic backpressure_stalls();
        int    i;
        int    stall;
        addr_t addr;
        for (i = 0; i < RAND_FETCHES; i++) begin
            addr = lcg_next();
            if (addr[31]) begin
                addr = UNCACHED_BASE | (addr & 32'h0FFF_FFFC);
            end else begin
                addr = addr & 32'h0000_3FFC;    // Small cached window, some hits
            end
            stall = int'(lcg_next() % 6);
            fetch($sformatf("backpressure_%0d", i), addr, stall, -1, 1'b0);
        end
    endtask

    initial begin
        clk         = 1'b0;
        nrst        = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        resp_ready  = 1'b1;
        flush_valid = 1'b0;
        flush_addr  = '0;
        lcg_state   = LCG_SEED;

        reset_and_init();
        cold_miss_and_hit();
        lru_replacement();
        uncached_fetches();
        fault_fetches();
        flush_and_refetch();
        backpressure_stalls();

        $display("Test passed");
        $finish;
    end

    // Budget of 200 cycles per fetch
    initial begin
        #(NUM_FETCHES * 200 * CLK_PERIOD);
        report_error("watchdog expired before the tests finished");
    end

endmodule

// File: sources.f
+incdir+src
src/icache_pkg.sv
src/icache_tag_mem.sv
src/icache_fill_master.sv
src/icache_ctrl.sv
src/icache_top.sv
verification/wb_mem_model.sv
verification/tb_icache.sv
